//--- include/rw_params.svh
// Read/write engine widths and request FIFO depth shared by the package and the RTL
`ifndef RW_PARAMS_SVH
`define RW_PARAMS_SVH

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------
// Memory address bus
`define RW_ADDR_WIDTH 32
// Engine data word, also the request payload word
`define RW_DATA_WIDTH 32
// Vertex index, read tag and job request count
`define RW_INDEX_WIDTH 16
// Stride shift applied to the index
`define RW_SHIFT_WIDTH 3

// ----------------------------------------------------------
// Buffering
// ----------------------------------------------------------
`define RW_FIFO_DEPTH 8

`endif

//--- verilog/rw_pkg.sv
// Type definitions for the read/write engine job, packets and memory requests
`include "rw_params.svh"

package rw_pkg;

    // ----------------------------------------------------------
    // Job setup
    // ----------------------------------------------------------
    // Configuration word arriving on the memory response channel
    typedef struct packed {
        logic [`RW_ADDR_WIDTH-1:0]  base_addr;
        logic [`RW_SHIFT_WIDTH-1:0] stride_shift;
        logic                       write_mode;
    } rw_config_t;

    // Descriptor, carries only the request count of the job
    typedef struct packed {
        logic                       valid;
        logic [`RW_INDEX_WIDTH-1:0] count;
    } rw_descriptor_t;

    // Configuration merged with the count at job start
    typedef struct packed {
        rw_config_t                 cfg;
        logic [`RW_INDEX_WIDTH-1:0] count;
    } rw_job_t;

    // ----------------------------------------------------------
    // Engine side and memory side
    // ----------------------------------------------------------
    typedef struct packed {
        logic [`RW_INDEX_WIDTH-1:0] index;
        logic [`RW_DATA_WIDTH-1:0]  data;
    } rw_engine_packet_t;

    // Read view of the payload, upper half held at zero
    typedef struct packed {
        logic [`RW_DATA_WIDTH-`RW_INDEX_WIDTH-1:0] reserved;
        logic [`RW_INDEX_WIDTH-1:0]                tag;
    } rw_read_tag_t;

    // Same word, decoded by the command
    typedef union packed {
        logic [`RW_DATA_WIDTH-1:0] write_data;
        rw_read_tag_t              read_tag;
    } rw_payload_u;

    typedef enum logic {
        RW_CMD_READ  = 1'b0,
        RW_CMD_WRITE = 1'b1
    } rw_cmd_e;

    typedef struct packed {
        rw_cmd_e                   cmd;
        logic [`RW_ADDR_WIDTH-1:0] addr;
        rw_payload_u               payload;
    } rw_mem_request_t;

endpackage : rw_pkg

//--- verilog/rw_job_capture.sv
// Job capture, holds the latest configuration word and launches a job per descriptor
module rw_job_capture (
    input  logic               ap_clk,
    input  logic               areset_read_write_engine,
    input  rw_pkg::rw_config_t     response_memory_in,
    input  logic               response_memory_valid,
    input  rw_pkg::rw_descriptor_t descriptor_in,
    output rw_pkg::rw_job_t        job,
    output logic               job_start
);

    import rw_pkg::*;

    // Most recent configuration seen on the response channel
    rw_config_t cfg_reg;
    // Configuration that a descriptor in this cycle would pick up
    rw_config_t cfg_next;

    // ----------------------------------------------------------
    // Configuration hold
    // ----------------------------------------------------------
    // A word in the same cycle as the descriptor wins over the held one
    assign cfg_next = response_memory_valid ? response_memory_in : cfg_reg;

    always_ff @(posedge ap_clk) begin
        if (response_memory_valid) begin
            cfg_reg <= response_memory_in;
        end
    end

    // ----------------------------------------------------------
    // Job launch
    // ----------------------------------------------------------
    // One-cycle pulse after the descriptor
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            job_start <= 1'b0;
        end else begin
            job_start <= descriptor_in.valid;
        end
    end

    // Job word handed to the generator and issue stage with job_start
    always_ff @(posedge ap_clk) begin
        if (descriptor_in.valid) begin
            job.cfg   <= cfg_next;
            job.count <= descriptor_in.count;
        end
    end

endmodule : rw_job_capture

//--- verilog/rw_request_generator.sv
// Request generator, turns engine packets into memory requests for the active job
`include "rw_params.svh"

module rw_request_generator (
    input  logic                     ap_clk,
    input  logic                     areset_read_write_engine,
    input  rw_pkg::rw_job_t           job,
    input  logic                     job_start,
    input  rw_pkg::rw_engine_packet_t engine_in,
    input  logic                     engine_in_valid,
    output logic                     engine_in_ready,
    output rw_pkg::rw_mem_request_t   gen_request,
    output logic                     gen_valid,
    input  logic                     gen_ready
);

    import rw_pkg::*;

    // Packets still to accept in this job
    logic [`RW_INDEX_WIDTH-1:0] accept_left;
    // Active job, held from job_start
    rw_config_t                 job_cfg;
    logic                       engine_accept;
    // Zero-extended index before the stride shift
    logic [`RW_ADDR_WIDTH-1:0]  index_ext;
    rw_mem_request_t            built_request;

    // ----------------------------------------------------------
    // Accept control
    // ----------------------------------------------------------
    // Output register drains whenever gen_ready is high, so ready
    // only needs the FIFO state and the remaining count
    assign engine_in_ready = (accept_left != '0) && gen_ready;
    assign engine_accept   = engine_in_valid && engine_in_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            accept_left <= '0;
        end else if (job_start) begin
            accept_left <= job.count;
        end else if (engine_accept) begin
            accept_left <= accept_left - 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (job_start) begin
            job_cfg <= job.cfg;
        end
    end

    // ----------------------------------------------------------
    // Request build
    // ----------------------------------------------------------
    assign index_ext = {{(`RW_ADDR_WIDTH-`RW_INDEX_WIDTH){1'b0}}, engine_in.index};

    always_comb begin
        built_request      = '0;
        built_request.addr = job_cfg.base_addr + (index_ext << job_cfg.stride_shift);
        if (job_cfg.write_mode) begin
            built_request.cmd                  = RW_CMD_WRITE;
            built_request.payload.write_data   = engine_in.data;
        end else begin
            // Read carries the index back as its tag
            built_request.cmd                   = RW_CMD_READ;
            built_request.payload.read_tag.tag      = engine_in.index;
            built_request.payload.read_tag.reserved = '0;
        end
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            gen_valid <= 1'b0;
        end else if (engine_accept) begin
            gen_valid <= 1'b1;
        end else if (gen_ready) begin
            gen_valid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (engine_accept) begin
            gen_request <= built_request;
        end
    end

endmodule : rw_request_generator

//--- verilog/rw_request_fifo.sv
// Request FIFO, circular buffer between the generator and the issue stage
`include "rw_params.svh"

module rw_request_fifo #(
    parameter int DEPTH = `RW_FIFO_DEPTH
) (
    input  logic                   ap_clk,
    input  logic                   areset_read_write_engine,
    input  rw_pkg::rw_mem_request_t in_request,
    input  logic                   in_valid,
    output logic                   in_ready,
    output rw_pkg::rw_mem_request_t out_request,
    output logic                   out_valid,
    input  logic                   out_ready
);

    import rw_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    // Occupancy needs one bit more than the pointers
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    rw_mem_request_t  mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // ----------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------
    assign in_ready    = (count != FULL_COUNT);
    assign out_valid   = (count != '0);
    assign push        = in_valid && in_ready;
    assign pop         = out_valid && out_ready;
    assign out_request = mem[rd_ptr];

    // Storage, written only on push
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_request;
        end
    end

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    // Power-of-two depth lets the pointers wrap on their own
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : rw_request_fifo

//--- verilog/rw_request_issue.sv
// Issue stage, registers requests toward memory and flags job completion
`include "rw_params.svh"

module rw_request_issue (
    input  logic                   ap_clk,
    input  logic                   areset_read_write_engine,
    input  rw_pkg::rw_job_t         job,
    input  logic                   job_start,
    input  rw_pkg::rw_mem_request_t fifo_request,
    input  logic                   fifo_valid,
    output logic                   fifo_ready,
    output rw_pkg::rw_mem_request_t request_memory_out,
    output logic                   request_memory_valid,
    input  logic                   request_memory_ready,
    output logic                   done
);

    // Requests of the job not yet handed to memory
    logic [`RW_INDEX_WIDTH-1:0] issue_left;
    logic                       load;
    logic                       issue;

    // ----------------------------------------------------------
    // One-entry output register
    // ----------------------------------------------------------
    // Refill when empty or when the current entry leaves this cycle
    assign fifo_ready = !request_memory_valid || request_memory_ready;
    assign load       = fifo_valid && fifo_ready;
    assign issue      = request_memory_valid && request_memory_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            request_memory_valid <= 1'b0;
        end else if (load) begin
            request_memory_valid <= 1'b1;
        end else if (request_memory_ready) begin
            request_memory_valid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (load) begin
            request_memory_out <= fifo_request;
        end
    end

    // ----------------------------------------------------------
    // Completion tracking
    // ----------------------------------------------------------
    // Empty job completes right away, otherwise on its last transfer
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            issue_left <= '0;
            done       <= 1'b0;
        end else if (job_start) begin
            issue_left <= job.count;
            done       <= (job.count == '0);
        end else if (issue && (issue_left != '0)) begin
            issue_left <= issue_left - 1'b1;
            if (issue_left == `RW_INDEX_WIDTH'(1)) begin
                done <= 1'b1;
            end
        end
    end

endmodule : rw_request_issue

//--- verilog/engine_read_write.sv
// Read/write engine top, job capture feeding generator, request FIFO and issue stage
module engine_read_write (
    input  logic                     ap_clk,
    input  logic                     areset_read_write_engine,
    input  rw_pkg::rw_config_t        response_memory_in,
    input  logic                     response_memory_valid,
    input  rw_pkg::rw_descriptor_t    descriptor_in,
    input  rw_pkg::rw_engine_packet_t engine_in,
    input  logic                     engine_in_valid,
    output logic                     engine_in_ready,
    output rw_pkg::rw_mem_request_t   request_memory_out,
    output logic                     request_memory_valid,
    input  logic                     request_memory_ready,
    output logic                     done
);

    import rw_pkg::*;

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------
    rw_job_t         job;
    logic            job_start;
    // Generator to FIFO
    rw_mem_request_t gen_request;
    logic            gen_valid;
    logic            gen_ready;
    // FIFO to issue stage
    rw_mem_request_t fifo_request;
    logic            fifo_valid;
    logic            fifo_ready;

    rw_job_capture u_job_capture (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .response_memory_in      (response_memory_in),
        .response_memory_valid   (response_memory_valid),
        .descriptor_in           (descriptor_in),
        .job                     (job),
        .job_start               (job_start)
    );

    rw_request_generator u_request_generator (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .job                     (job),
        .job_start               (job_start),
        .engine_in               (engine_in),
        .engine_in_valid         (engine_in_valid),
        .engine_in_ready         (engine_in_ready),
        .gen_request             (gen_request),
        .gen_valid               (gen_valid),
        .gen_ready               (gen_ready)
    );

    rw_request_fifo u_request_fifo (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .in_request              (gen_request),
        .in_valid                (gen_valid),
        .in_ready                (gen_ready),
        .out_request             (fifo_request),
        .out_valid               (fifo_valid),
        .out_ready               (fifo_ready)
    );

    rw_request_issue u_request_issue (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .job                     (job),
        .job_start               (job_start),
        .fifo_request            (fifo_request),
        .fifo_valid              (fifo_valid),
        .fifo_ready              (fifo_ready),
        .request_memory_out      (request_memory_out),
        .request_memory_valid    (request_memory_valid),
        .request_memory_ready    (request_memory_ready),
        .done                    (done)
    );

endmodule : engine_read_write

//--- dv/engine_read_write_chk.sv
// Read/write engine handshake assertions, bound to the top level
module engine_read_write_chk (
    input logic                    ap_clk,
    input logic                    areset_read_write_engine,
    input logic                    engine_in_ready,
    input rw_pkg::rw_mem_request_t request_memory_out,
    input logic                    request_memory_valid,
    input logic                    request_memory_ready,
    input logic                    done
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------
    // Memory request channel
    // ------------------------------------------------------------
    // Stalled request keeps valid and payload until taken
    property stall_holds_request;
        @(posedge ap_clk) disable iff (areset_read_write_engine)
            (request_memory_valid && !request_memory_ready)
            |=> (request_memory_valid && $stable(request_memory_out));
    endproperty

    // Nothing offered to memory right out of reset
    property idle_after_reset;
        @(posedge ap_clk) areset_read_write_engine |=> !request_memory_valid;
    endproperty

    // Finished job takes no more packets
    property done_blocks_engine;
        @(posedge ap_clk) disable iff (areset_read_write_engine)
            done |-> !engine_in_ready;
    endproperty

    a_stall_holds_request: assert property (stall_holds_request)
        else $error("request_memory_out dropped or changed while stalled");
    a_idle_after_reset: assert property (idle_after_reset)
        else $error("request_memory_valid high in the cycle after reset");
    a_done_blocks_engine: assert property (done_blocks_engine)
        else $error("engine_in_ready high while done is high");

endmodule : engine_read_write_chk

//--- dv/tb_engine_read_write.sv
// Read/write engine testbench, table of jobs with LFSR packets and an in-order request scoreboard
`include "rw_params.svh"

module tb_engine_read_write;

    timeunit 1ns;
    timeprecision 1ps;

    import rw_pkg::*;

    // One job of the table
    typedef struct packed {
        logic                       write_mode;
        logic [`RW_ADDR_WIDTH-1:0]  base_addr;
        logic [`RW_SHIFT_WIDTH-1:0] stride_shift;
        logic [`RW_INDEX_WIDTH-1:0] count;
        logic                       backpressure;
    } job_row_t;

    localparam int NUM_JOBS = 5;

    logic              ap_clk;
    logic              areset_read_write_engine;
    rw_config_t        response_memory_in;
    logic              response_memory_valid;
    rw_descriptor_t    descriptor_in;
    rw_engine_packet_t engine_in;
    logic              engine_in_valid;
    logic              engine_in_ready;
    rw_mem_request_t   request_memory_out;
    logic              request_memory_valid;
    logic              request_memory_ready;
    logic              done;

    job_row_t          jobs [NUM_JOBS];
    // Packets to send and requests still owed by the DUT
    rw_engine_packet_t packets [$];
    rw_mem_request_t   expected [$];
    logic [31:0]       lfsr_state;
    int                value_errors;
    int                protocol_errors;
    int                timeouts;

    engine_read_write dut_i (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .response_memory_in      (response_memory_in),
        .response_memory_valid   (response_memory_valid),
        .descriptor_in           (descriptor_in),
        .engine_in               (engine_in),
        .engine_in_valid         (engine_in_valid),
        .engine_in_ready         (engine_in_ready),
        .request_memory_out      (request_memory_out),
        .request_memory_valid    (request_memory_valid),
        .request_memory_ready    (request_memory_ready),
        .done                    (done)
    );

    bind engine_read_write engine_read_write_chk chk_i (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .engine_in_ready         (engine_in_ready),
        .request_memory_out      (request_memory_out),
        .request_memory_valid    (request_memory_valid),
        .request_memory_ready    (request_memory_ready),
        .done                    (done)
    );

    // 4 ns clock
    initial begin
        ap_clk = 1'b0;
        forever begin
            #2 ap_clk = ~ap_clk;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic check_field(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
        if (actual !== want) begin
            value_errors++;
            $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, want);
        end
    endtask

    task automatic fill_job_table();
        // mode, base address, stride shift, count, back-pressure
        jobs[0] = '{1'b1, 32'h1000_0000, 3'd2, 16'd12, 1'b0};
        jobs[1] = '{1'b0, 32'h2000_0400, 3'd3, 16'd10, 1'b0};
        jobs[2] = '{1'b1, 32'h3000_0000, 3'd0, 16'd20, 1'b1};
        // Empty job, done without any request
        jobs[3] = '{1'b1, 32'h0000_1000, 3'd1, 16'd0, 1'b0};
        // Large shift lets the address wrap
        jobs[4] = '{1'b0, 32'hFFFF_0000, 3'd7, 16'd16, 1'b1};
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Address is base plus index shifted, payload is data or the index as tag
    task automatic build_expected(input job_row_t row);
        logic [31:0]       rnd;
        logic [31:0]       ext_index;
        rw_engine_packet_t pkt;
        rw_mem_request_t   req;
        for (int i = 0; i < int'(row.count); i++) begin
            draw_bits(`RW_INDEX_WIDTH, rnd);
            pkt.index = rnd[`RW_INDEX_WIDTH-1:0];
            draw_bits(`RW_DATA_WIDTH, rnd);
            pkt.data  = rnd;
            packets.push_back(pkt);
            ext_index = '0;
            ext_index[`RW_INDEX_WIDTH-1:0] = pkt.index;
            req.cmd   = row.write_mode ? RW_CMD_WRITE : RW_CMD_READ;
            req.addr  = row.base_addr + (ext_index << row.stride_shift);
            req.payload.write_data = row.write_mode ? pkt.data : ext_index;
            expected.push_back(req);
        end
    endtask

    // Compare the request leaving on this cycle against the oldest expected one
    task automatic check_transfer(input logic write_mode);
        rw_mem_request_t want;
        want = expected.pop_front();
        check_field("request_memory_out.cmd", 32'(request_memory_out.cmd), 32'(want.cmd));
        check_field("request_memory_out.addr", request_memory_out.addr, want.addr);
        if (write_mode) begin
            check_field("request_memory_out.payload.write_data",
                        request_memory_out.payload.write_data, want.payload.write_data);
        end else begin
            check_field("request_memory_out.payload.read_tag.tag",
                        32'(request_memory_out.payload.read_tag.tag),
                        32'(want.payload.read_tag.tag));
            check_field("request_memory_out.payload.read_tag.reserved",
                        32'(request_memory_out.payload.read_tag.reserved), 32'd0);
        end
    endtask

    // ------------------------------------------------------------
    // One job: configuration, descriptor, packets, drain
    // ------------------------------------------------------------
    task automatic run_job(input job_row_t row, output logic timed_out);
        int              cyc;
        int              sent;
        int              got;
        int              limit;
        logic [31:0]     rnd;
        logic            stalled;
        rw_mem_request_t held;
        timed_out = 1'b0;
        packets.delete();
        build_expected(row);
        response_memory_in.base_addr    = row.base_addr;
        response_memory_in.stride_shift = row.stride_shift;
        response_memory_in.write_mode   = row.write_mode;
        response_memory_valid           = 1'b1;
        next_cycle();
        response_memory_valid = 1'b0;
        descriptor_in.valid   = 1'b1;
        descriptor_in.count   = row.count;
        next_cycle();
        descriptor_in.valid = 1'b0;
        cyc     = 0;
        sent    = 0;
        got     = 0;
        stalled = 1'b0;
        held    = '0;
        limit   = 64 + 8 * int'(row.count);
        // First pass is the job_start cycle, done is only stable after it
        while ((got < int'(row.count) || cyc < 1) && cyc < limit) begin
            engine_in_valid = (sent < int'(row.count));
            if (engine_in_valid) begin
                engine_in = packets[sent];
            end
            if (row.backpressure) begin
                draw_bits(1, rnd);
                request_memory_ready = rnd[0];
            end else begin
                request_memory_ready = 1'b1;
            end
            if (stalled && (!request_memory_valid || request_memory_out !== held)) begin
                protocol_errors++;
                $display("Stalled memory request dropped or changed at %0d ns", $time);
            end
            if (cyc >= 1 && done) begin
                protocol_errors++;
                $display("done high at %0d ns with %0d requests outstanding", $time,
                         int'(row.count) - got);
            end
            if (request_memory_valid && request_memory_ready) begin
                check_transfer(row.write_mode);
                got++;
            end
            if (engine_in_valid && engine_in_ready) begin
                sent++;
            end
            stalled = request_memory_valid && !request_memory_ready;
            held    = request_memory_out;
            next_cycle();
            cyc++;
        end
        engine_in_valid = 1'b0;
        if (got < int'(row.count)) begin
            timed_out = 1'b1;
            timeouts++;
            $display("Timeout: job stopped after %0d of %0d requests", got, row.count);
        end else begin
            // Cycle after the last transfer
            check_field("done", 32'(done), 32'd1);
            check_field("engine_in_ready", 32'(engine_in_ready), 32'd0);
            check_field("request_memory_valid", 32'(request_memory_valid), 32'd0);
            if (sent != int'(row.count)) begin
                protocol_errors++;
                $display("Job finished with %0d of %0d engine packets accepted", sent,
                         row.count);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic timed_out;
        areset_read_write_engine = 1'b1;
        response_memory_in       = '0;
        response_memory_valid    = 1'b0;
        descriptor_in            = '0;
        engine_in                = '0;
        engine_in_valid          = 1'b0;
        request_memory_ready     = 1'b0;
        lfsr_state               = 32'h19be75f9;
        value_errors             = 0;
        protocol_errors          = 0;
        timeouts                 = 0;
        fill_job_table();
        repeat (16) @(posedge ap_clk);
        #1;
        areset_read_write_engine = 1'b0;
        // Idle outputs after reset
        check_field("engine_in_ready", 32'(engine_in_ready), 32'd0);
        check_field("request_memory_valid", 32'(request_memory_valid), 32'd0);
        check_field("done", 32'(done), 32'd0);
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(jobs[j], timed_out);
            if (timed_out) begin
                break;
            end
        end
        $display("Errors: %0d value, %0d protocol, %0d timeout", value_errors,
                 protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_engine_read_write

//--- all.f
+incdir+include
verilog/rw_pkg.sv
verilog/rw_job_capture.sv
verilog/rw_request_generator.sv
verilog/rw_request_fifo.sv
verilog/rw_request_issue.sv
verilog/engine_read_write.sv
dv/engine_read_write_chk.sv
dv/tb_engine_read_write.sv

//--- run.sh
#!/bin/sh
# Build and run the read/write engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_engine_read_write -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_engine_read_write > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
